// ==== src/clint_pkg.sv ====
// CLINT shared widths, register map offsets and AXI response codes
`default_nettype none

package clint_pkg;

    // AXI bus widths
    localparam int CLINT_ADDR_W = 32;
    localparam int CLINT_DATA_W = 64;
    localparam int CLINT_STRB_W = CLINT_DATA_W / 8;
    localparam int CLINT_ID_W   = 4;

    // Register offsets from the window base
    localparam logic [CLINT_ADDR_W-1:0] OFS_MSIP     = 32'h0000_0000;
    localparam logic [CLINT_ADDR_W-1:0] OFS_MTIMECMP = 32'h0000_4000;
    localparam logic [CLINT_ADDR_W-1:0] OFS_MTIME    = 32'h0000_BFF8;

    // Register select, REG_NONE for an unmapped address
    typedef enum logic [1:0] {
        REG_MSIP     = 2'd0,
        REG_MTIMECMP = 2'd1,
        REG_MTIME    = 2'd2,
        REG_NONE     = 2'd3
    } clint_reg_e;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;
    localparam axi_resp_t RESP_DECERR = 2'b11;

endpackage

`default_nettype wire

// ==== src/clint_reg_if.sv ====
// CLINT register access strobe from the AXI decoder to the timer and responder
`timescale 1ns/1ps
`default_nettype none

interface clint_reg_if import clint_pkg::*; ();

    logic                    req;    // One cycle per accepted request
    logic                    we;
    clint_reg_e              sel;
    axi_resp_t               err;
    logic [CLINT_ID_W-1:0]   id;
    logic [CLINT_DATA_W-1:0] wdata;
    logic [CLINT_STRB_W-1:0] wstrb;
    logic [CLINT_DATA_W-1:0] rdata;  // Combinational from sel

    modport decoder (
        output req, we, sel, err, id, wdata, wstrb
    );

    modport timer (
        input  req, we, sel, err, wdata, wstrb,
        output rdata
    );

    modport responder (
        input req, we, err, id, rdata
    );

endinterface

`default_nettype wire

// ==== src/clint_axi_decode.sv ====
// CLINT AXI request decode, read-first arbitration and address/len checks
`timescale 1ns/1ps
`default_nettype none

module clint_axi_decode import clint_pkg::*; #(
    parameter logic [CLINT_ADDR_W-1:0] BASE_ADDR = 32'h0200_0000
) (
    input  wire logic                    aclk,
    input  wire logic                    areset_n,

    input  wire logic                    ar_valid_i,
    input  wire logic [CLINT_ADDR_W-1:0] ar_addr_i,
    input  wire logic [CLINT_ID_W-1:0]   ar_id_i,
    input  wire logic [7:0]              ar_len_i,
    output      logic                    ar_ready_o,

    input  wire logic                    aw_valid_i,
    input  wire logic [CLINT_ADDR_W-1:0] aw_addr_i,
    input  wire logic [CLINT_ID_W-1:0]   aw_id_i,
    input  wire logic [7:0]              aw_len_i,
    output      logic                    aw_ready_o,

    input  wire logic                    w_valid_i,
    input  wire logic [CLINT_DATA_W-1:0] w_data_i,
    input  wire logic [CLINT_STRB_W-1:0] w_strb_i,
    output      logic                    w_ready_o,

    input  wire logic                    busy_i,
    clint_reg_if.decoder                 reg_if
);

    logic                    rdy_en;  // Low in reset, high from the first cycle after
    logic                    ar_hs;
    logic                    wr_hs;
    logic [CLINT_ADDR_W-1:0] addr;
    logic [7:0]              len;
    clint_reg_e              sel;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            rdy_en <= 1'b0;
        end else begin
            rdy_en <= 1'b1;
        end
    end

    assign ar_ready_o = rdy_en & ~busy_i;
    // Write only with AW and W both present and no read waiting
    assign aw_ready_o = rdy_en & ~busy_i & ~ar_valid_i & aw_valid_i & w_valid_i;
    assign w_ready_o  = aw_ready_o;

    assign ar_hs = ar_valid_i & ar_ready_o;
    assign wr_hs = aw_valid_i & aw_ready_o & w_valid_i;

    assign addr = ar_hs ? ar_addr_i : aw_addr_i;
    assign len  = ar_hs ? ar_len_i : aw_len_i;

    always_comb begin
        if (addr == BASE_ADDR + OFS_MSIP) begin
            sel = REG_MSIP;
        end else if (addr == BASE_ADDR + OFS_MTIMECMP) begin
            sel = REG_MTIMECMP;
        end else if (addr == BASE_ADDR + OFS_MTIME) begin
            sel = REG_MTIME;
        end else begin
            sel = REG_NONE;
        end
    end

    assign reg_if.req   = ar_hs | wr_hs;
    assign reg_if.we    = wr_hs;
    assign reg_if.sel   = sel;
    assign reg_if.id    = ar_hs ? ar_id_i : aw_id_i;
    assign reg_if.wdata = w_data_i;
    assign reg_if.wstrb = w_strb_i;

    // Unmapped address outranks a bad length
    assign reg_if.err = (sel == REG_NONE) ? RESP_DECERR :
                        (len != 8'd0)     ? RESP_SLVERR : RESP_OKAY;

    // Each access leaves a response pending on the next cycle
    a_busy_after_req: assert property (
        @(posedge aclk) disable iff (areset_n) reg_if.req |=> busy_i
    );

endmodule

`default_nettype wire

// ==== src/clint_timer_exec.sv ====
// CLINT timer core with mtime, mtimecmp, msip registers and interrupt outputs
`timescale 1ns/1ps
`default_nettype none

module clint_timer_exec import clint_pkg::*; #(
    parameter int TICK_DIV = 1
) (
    input  wire logic  aclk,
    input  wire logic  areset_n,
    clint_reg_if.timer reg_if,
    output      logic  mtip_o,
    output      logic  msip_o
);

    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PRE_W-1:0]        pre_cnt;
    logic                    tick;
    logic [CLINT_DATA_W-1:0] mtime;
    logic [CLINT_DATA_W-1:0] mtimecmp;
    logic                    msip;
    logic                    wr_en;

    function automatic logic [CLINT_DATA_W-1:0] strb_merge(
        input logic [CLINT_DATA_W-1:0] old_v,
        input logic [CLINT_DATA_W-1:0] new_v,
        input logic [CLINT_STRB_W-1:0] strb
    );
        logic [CLINT_DATA_W-1:0] res;
        res = old_v;
        for (int i = 0; i < CLINT_STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign wr_en = reg_if.req & reg_if.we & (reg_if.err == RESP_OKAY);
    assign tick  = (pre_cnt == PRE_W'(TICK_DIV - 1));

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            pre_cnt  <= '0;
            mtime    <= '0;
            mtimecmp <= '0;
            msip     <= 1'b0;
            mtip_o   <= 1'b0;
            msip_o   <= 1'b0;
        end else begin
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
            if (wr_en && reg_if.sel == REG_MTIME) begin
                mtime <= strb_merge(mtime, reg_if.wdata, reg_if.wstrb);  // Beats the tick
            end else if (tick) begin
                mtime <= mtime + 1'b1;
            end
            if (wr_en && reg_if.sel == REG_MTIMECMP) begin
                mtimecmp <= strb_merge(mtimecmp, reg_if.wdata, reg_if.wstrb);
            end
            if (wr_en && reg_if.sel == REG_MSIP && reg_if.wstrb[0]) begin
                msip <= reg_if.wdata[0];  // Only bit 0 exists
            end
            mtip_o <= (mtime >= mtimecmp);
            msip_o <= msip;
        end
    end

    always_comb begin
        case (reg_if.sel)
            REG_MSIP:     reg_if.rdata = {{(CLINT_DATA_W-1){1'b0}}, msip};
            REG_MTIMECMP: reg_if.rdata = mtimecmp;
            REG_MTIME:    reg_if.rdata = mtime;
            default:      reg_if.rdata = '0;
        endcase
    end

    // Write enable and response code must be resolved on every access
    a_ctrl_known: assert property (
        @(posedge aclk) disable iff (areset_n)
            reg_if.req |-> !$isunknown({reg_if.we, reg_if.err})
    );

endmodule

`default_nettype wire

// ==== src/clint_axi_result.sv ====
// CLINT AXI R and B response registers held until the master accepts them
`timescale 1ns/1ps
`default_nettype none

module clint_axi_result import clint_pkg::*; (
    input  wire logic                    aclk,
    input  wire logic                    areset_n,
    clint_reg_if.responder               reg_if,

    input  wire logic                    r_ready_i,
    output      logic                    r_valid_o,
    output      logic [CLINT_DATA_W-1:0] r_data_o,
    output      axi_resp_t               r_resp_o,
    output      logic                    r_last_o,
    output      logic [CLINT_ID_W-1:0]   r_id_o,

    input  wire logic                    b_ready_i,
    output      logic                    b_valid_o,
    output      axi_resp_t               b_resp_o,
    output      logic [CLINT_ID_W-1:0]   b_id_o,

    output      logic                    busy_o
);

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            r_valid_o <= 1'b0;
            r_last_o  <= 1'b0;
            b_valid_o <= 1'b0;
        end else begin
            if (reg_if.req && !reg_if.we) begin
                r_valid_o <= 1'b1;
                r_last_o  <= 1'b1;  // Single beat, always last
            end else if (r_ready_i) begin
                r_valid_o <= 1'b0;
                r_last_o  <= 1'b0;
            end
            if (reg_if.req && reg_if.we) begin
                b_valid_o <= 1'b1;
            end else if (b_ready_i) begin
                b_valid_o <= 1'b0;
            end
        end
    end

    // Payloads load only on a new request
    always_ff @(posedge aclk) begin
        if (reg_if.req && !reg_if.we) begin
            r_data_o <= (reg_if.err == RESP_OKAY) ? reg_if.rdata : '0;
            r_resp_o <= reg_if.err;
            r_id_o   <= reg_if.id;
        end
        if (reg_if.req && reg_if.we) begin
            b_resp_o <= reg_if.err;
            b_id_o   <= reg_if.id;
        end
    end

    assign busy_o = r_valid_o | b_valid_o;

    a_one_response: assert property (
        @(posedge aclk) disable iff (areset_n) !(r_valid_o && b_valid_o)
    );

endmodule

`default_nettype wire

// ==== src/clint_top.sv ====
// CLINT top level with an AXI4 slave port and timer/software interrupt outputs
`timescale 1ns/1ps
`default_nettype none

module clint_top import clint_pkg::*; #(
    parameter logic [CLINT_ADDR_W-1:0] BASE_ADDR = 32'h0200_0000,
    parameter int                      TICK_DIV  = 1
) (
    input  wire logic                    aclk,
    input  wire logic                    areset_n,

    output      logic                    axi_aw_ready_o,
    input  wire logic                    axi_aw_valid_i,
    input  wire logic [CLINT_ADDR_W-1:0] axi_aw_addr_i,
    input  wire logic [CLINT_ID_W-1:0]   axi_aw_id_i,
    input  wire logic [7:0]              axi_aw_len_i,
    input  wire logic [2:0]              axi_aw_size_i,   // Full width assumed
    input  wire logic [1:0]              axi_aw_burst_i,
    output      logic                    axi_w_ready_o,
    input  wire logic                    axi_w_valid_i,
    input  wire logic [CLINT_DATA_W-1:0] axi_w_data_i,
    input  wire logic [CLINT_STRB_W-1:0] axi_w_strb_i,
    input  wire logic                    axi_w_last_i,
    input  wire logic                    axi_b_ready_i,
    output      logic                    axi_b_valid_o,
    output      logic [1:0]              axi_b_resp_o,
    output      logic [CLINT_ID_W-1:0]   axi_b_id_o,
    output      logic                    axi_ar_ready_o,
    input  wire logic                    axi_ar_valid_i,
    input  wire logic [CLINT_ADDR_W-1:0] axi_ar_addr_i,
    input  wire logic [CLINT_ID_W-1:0]   axi_ar_id_i,
    input  wire logic [7:0]              axi_ar_len_i,
    input  wire logic [2:0]              axi_ar_size_i,
    input  wire logic [1:0]              axi_ar_burst_i,
    input  wire logic                    axi_r_ready_i,
    output      logic                    axi_r_valid_o,
    output      logic [CLINT_DATA_W-1:0] axi_r_data_o,
    output      logic [1:0]              axi_r_resp_o,
    output      logic                    axi_r_last_o,
    output      logic [CLINT_ID_W-1:0]   axi_r_id_o,

    output      logic                    mtip_o,
    output      logic                    msip_o
);

    logic busy;

    clint_reg_if reg_if ();

    clint_axi_decode #(.BASE_ADDR(BASE_ADDR)) u_decode (
        .aclk(aclk), .areset_n(areset_n),
        .ar_valid_i(axi_ar_valid_i), .ar_addr_i(axi_ar_addr_i),
        .ar_id_i(axi_ar_id_i), .ar_len_i(axi_ar_len_i), .ar_ready_o(axi_ar_ready_o),
        .aw_valid_i(axi_aw_valid_i), .aw_addr_i(axi_aw_addr_i),
        .aw_id_i(axi_aw_id_i), .aw_len_i(axi_aw_len_i), .aw_ready_o(axi_aw_ready_o),
        .w_valid_i(axi_w_valid_i), .w_data_i(axi_w_data_i),
        .w_strb_i(axi_w_strb_i), .w_ready_o(axi_w_ready_o),
        .busy_i(busy), .reg_if(reg_if.decoder)
    );

    clint_timer_exec #(.TICK_DIV(TICK_DIV)) u_timer (
        .aclk(aclk), .areset_n(areset_n), .reg_if(reg_if.timer),
        .mtip_o(mtip_o), .msip_o(msip_o)
    );

    clint_axi_result u_result (
        .aclk(aclk), .areset_n(areset_n), .reg_if(reg_if.responder),
        .r_ready_i(axi_r_ready_i), .r_valid_o(axi_r_valid_o), .r_data_o(axi_r_data_o),
        .r_resp_o(axi_r_resp_o), .r_last_o(axi_r_last_o), .r_id_o(axi_r_id_o),
        .b_ready_i(axi_b_ready_i), .b_valid_o(axi_b_valid_o),
        .b_resp_o(axi_b_resp_o), .b_id_o(axi_b_id_o),
        .busy_o(busy)
    );

endmodule

`default_nettype wire

// ==== verification/clint_tb.sv ====
// CLINT testbench running AXI register accesses and interrupt checks from a vector file
`timescale 1ns/1ps
`default_nettype none

module clint_tb import clint_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int OP_CYCLES    = 64;  // Watchdog budget per operation

    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] addr;
        logic [63:0] data;
        logic [7:0]  strb;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [1:0]  resp;
        logic [63:0] expv;
    } op_t;

    logic                    aclk;
    logic                    areset_n;
    logic                    aw_valid;
    logic [CLINT_ADDR_W-1:0] aw_addr;
    logic [CLINT_ID_W-1:0]   aw_id;
    logic [7:0]              aw_len;
    logic                    w_valid;
    logic [CLINT_DATA_W-1:0] w_data;
    logic [CLINT_STRB_W-1:0] w_strb;
    logic                    b_ready;
    logic                    ar_valid;
    logic [CLINT_ADDR_W-1:0] ar_addr;
    logic [CLINT_ID_W-1:0]   ar_id;
    logic [7:0]              ar_len;
    logic                    r_ready;
    logic                    aw_ready;
    logic                    w_ready;
    logic                    b_valid;
    logic [1:0]              b_resp;
    logic [CLINT_ID_W-1:0]   b_id;
    logic                    ar_ready;
    logic                    r_valid;
    logic [CLINT_DATA_W-1:0] r_data;
    logic [1:0]              r_resp;
    logic                    r_last;
    logic [CLINT_ID_W-1:0]   r_id;
    logic                    mtip;
    logic                    msip;

    op_t         ops[$];
    int          op_count;
    int          errors;
    int          cycle_cnt;
    int          hs_cycle;    // Cycle of the last address transfer
    logic [63:0] last_mtime;

    clint_top dut_i (
        .aclk(aclk), .areset_n(areset_n),
        .axi_aw_ready_o(aw_ready), .axi_aw_valid_i(aw_valid), .axi_aw_addr_i(aw_addr),
        .axi_aw_id_i(aw_id), .axi_aw_len_i(aw_len), .axi_aw_size_i(3'd3),
        .axi_aw_burst_i(2'b01),
        .axi_w_ready_o(w_ready), .axi_w_valid_i(w_valid), .axi_w_data_i(w_data),
        .axi_w_strb_i(w_strb), .axi_w_last_i(1'b1),
        .axi_b_ready_i(b_ready), .axi_b_valid_o(b_valid), .axi_b_resp_o(b_resp),
        .axi_b_id_o(b_id),
        .axi_ar_ready_o(ar_ready), .axi_ar_valid_i(ar_valid), .axi_ar_addr_i(ar_addr),
        .axi_ar_id_i(ar_id), .axi_ar_len_i(ar_len), .axi_ar_size_i(3'd3),
        .axi_ar_burst_i(2'b01),
        .axi_r_ready_i(r_ready), .axi_r_valid_o(r_valid), .axi_r_data_o(r_data),
        .axi_r_resp_o(r_resp), .axi_r_last_o(r_last), .axi_r_id_o(r_id),
        .mtip_o(mtip), .msip_o(msip)
    );

    always #(CLK_PERIOD/2) aclk = ~aclk;

    always @(negedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;  // Stable at the rising edge
    end

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
        assert (got === exp) else begin
            errors++;
            $display("ERR %s exp=%h got=%h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    task automatic load_vectors;
        int          fd;
        int          c;
        int          n;
        op_t         op;
        logic [31:0] addr;
        logic [63:0] data;
        logic [7:0]  strb;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [1:0]  resp;
        logic [63:0] expv;
        fd = $fopen("verification/clint_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Error: the vector file could not be opened");
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (c > " ") begin  // Kind letter
                    n = $fscanf(fd, "%h %h %h %h %h %h %h", addr, data, strb, id, len, resp, expv);
                    if (n == 7) begin
                        op.kind = c[7:0];
                        op.addr = addr;
                        op.data = data;
                        op.strb = strb;
                        op.id   = id;
                        op.len  = len;
                        op.resp = resp;
                        op.expv = expv;
                        ops.push_back(op);
                    end else begin
                        errors++;
                        $display("Error: malformed line in the vector file");
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
        op_count = ops.size();
        expect_true(op_count > 0, "the vector file holds no operations");
    endtask

    function automatic logic [70:0] resp_payload(input logic is_read);
        if (is_read) begin
            return {r_data, r_resp, r_id, r_last};
        end
        return {64'd0, b_resp, b_id, 1'b1};
    endfunction

    task automatic drive_read(input op_t op);
        ar_valid = 1'b1;
        ar_addr  = op.addr;
        ar_id    = op.id;
        ar_len   = op.len;
    endtask

    task automatic drive_write(input op_t op);
        aw_valid = 1'b1;
        aw_addr  = op.addr;
        aw_id    = op.id;
        aw_len   = op.len;
        w_valid  = 1'b1;
        w_data   = op.data;
        w_strb   = op.strb;
    endtask

    // Ready is sampled in the low phase, the transfer happens at the next rising edge
    task automatic wait_addr_transfer(input logic is_read);
        #(CLK_PERIOD/4);
        while (!(is_read ? ar_ready : (aw_ready && w_ready))) begin
            @(negedge aclk);
            #(CLK_PERIOD/4);
        end
        @(posedge aclk);
        hs_cycle = cycle_cnt;
        @(negedge aclk);
        if (is_read) begin
            ar_valid = 1'b0;
        end else begin
            aw_valid = 1'b0;
            w_valid  = 1'b0;
        end
    endtask

    // Response must show up one cycle after the transfer and hold through the ready delay
    task automatic collect_resp(input logic is_read, output logic [70:0] bits);
        int dly;
        int i;
        dly  = $urandom % 6;
        bits = resp_payload(is_read);
        for (i = 0; i <= dly; i++) begin
            if (i > 0) begin
                @(negedge aclk);
            end
            expect_true((is_read ? r_valid : b_valid) === 1'b1,
                        "response valid missing or dropped before ready");
            expect_true(resp_payload(is_read) === bits, "response payload changed before ready");
            expect_true(!ar_ready && !aw_ready && !w_ready,
                        "a ready output is high while a response is pending");
        end
        r_ready = is_read;
        b_ready = !is_read;
        @(negedge aclk);
        r_ready = 1'b0;
        b_ready = 1'b0;
        expect_true(!r_valid && !b_valid, "response valid still high after the transfer");
        expect_true(ar_ready === 1'b1, "ar_ready low after the response transfer");
    endtask

    task automatic check_resp(input logic is_read, input logic [70:0] bits,
                              input logic [3:0] exp_id, input logic [1:0] exp_resp);
        compare_value(is_read ? "r_resp" : "b_resp", 64'(exp_resp), 64'(bits[6:5]));
        compare_value(is_read ? "r_id" : "b_id", 64'(exp_id), 64'(bits[4:1]));
        if (is_read) begin
            compare_value("r_last", 64'd1, 64'(bits[0]));
        end
    endtask

    task automatic send_read(input op_t op, output logic [70:0] bits);
        @(negedge aclk);
        drive_read(op);
        wait_addr_transfer(1'b1);
        collect_resp(1'b1, bits);
    endtask

    task automatic send_write(input op_t op, output logic [70:0] bits);
        @(negedge aclk);
        drive_write(op);
        wait_addr_transfer(1'b0);
        collect_resp(1'b0, bits);
    endtask

    task automatic run_op(input op_t op);
        logic [70:0] bits;
        op_t         wr_op;
        int          wr_cycle;
        wr_cycle = 0;
        case (op.kind)
            "W": begin
                send_write(op, bits);
                check_resp(1'b0, bits, op.id, op.resp);
            end
            "R": begin
                send_read(op, bits);
                check_resp(1'b1, bits, op.id, op.resp);
                compare_value("r_data", op.expv, bits[70:7]);
            end
            "T": begin
                if (op.strb != 8'h00) begin
                    send_write(op, bits);
                    check_resp(1'b0, bits, op.id, op.resp);
                    wr_cycle   = hs_cycle;
                    last_mtime = op.data;
                end
                send_read(op, bits);
                check_resp(1'b1, bits, op.id, op.resp);
                expect_true(bits[70:7] >= last_mtime, "mtime read went backwards");
                if (op.strb != 8'h00) begin
                    expect_true(bits[70:7] <= op.data + 64'(hs_cycle - wr_cycle) + 64'd2,
                                "mtime ran ahead of the cycles counted since the write");
                end
                last_mtime = bits[70:7];
            end
            "I": begin
                repeat (2) @(negedge aclk);
                compare_value("mtip_o", 64'(op.expv[1]), 64'(mtip));
                compare_value("msip_o", 64'(op.expv[0]), 64'(msip));
            end
            "P": begin
                wr_op    = op;
                wr_op.id = op.id + 4'd1;
                @(negedge aclk);
                drive_read(op);
                drive_write(wr_op);
                #(CLK_PERIOD/8);
                expect_true(ar_ready === 1'b1 && aw_ready === 1'b0,
                            "write was taken ahead of a simultaneous read");
                wait_addr_transfer(1'b1);
                collect_resp(1'b1, bits);
                check_resp(1'b1, bits, op.id, op.resp);
                compare_value("r_data", op.expv, bits[70:7]);
                wait_addr_transfer(1'b0);  // Write still pending
                collect_resp(1'b0, bits);
                check_resp(1'b0, bits, wr_op.id, op.resp);
            end
            default: begin
                errors++;
                $display("Error: unknown operation kind %c in the vector file", op.kind);
            end
        endcase
    endtask

    initial begin
        aclk       = 1'b0;
        areset_n   = 1'b1;
        aw_valid   = 1'b0;
        aw_addr    = '0;
        aw_id      = '0;
        aw_len     = '0;
        w_valid    = 1'b0;
        w_data     = '0;
        w_strb     = '0;
        b_ready    = 1'b0;
        ar_valid   = 1'b0;
        ar_addr    = '0;
        ar_id      = '0;
        ar_len     = '0;
        r_ready    = 1'b0;
        errors     = 0;
        cycle_cnt  = 0;
        hs_cycle   = 0;
        op_count   = 0;
        last_mtime = '0;
        void'($urandom(32'h20b1));
        load_vectors();
        repeat (RESET_CYCLES) @(negedge aclk);
        expect_true(!ar_ready && !aw_ready && !w_ready && !r_valid && !b_valid,
                    "ready or valid output high during reset");
        areset_n = 1'b0;
        @(negedge aclk);
        expect_true(ar_ready === 1'b1, "ar_ready not high in the first cycle after reset");
        foreach (ops[k]) begin
            repeat ($urandom % 4) @(negedge aclk);
            run_op(ops[k]);
        end
        $display("Errors: %0d in %0d operations", errors, op_count);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (op_count > 0);
        #(longint'(op_count) * OP_CYCLES * CLK_PERIOD);
        $display("Timeout: operations did not complete within %0d clock cycles",
                 op_count * OP_CYCLES);
        $display("Errors: %0d in %0d operations", errors, op_count);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
src/clint_pkg.sv
src/clint_reg_if.sv
src/clint_axi_decode.sv
src/clint_timer_exec.sv
src/clint_axi_result.sv
src/clint_top.sv
verification/clint_tb.sv

// ==== Makefile ====
TOP := clint_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module clint_top

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/clint_vectors.txt ====
# kind addr data strb id len resp expect  (I: expect = {mtip,msip}; T: strb 00 reads only)
# W write, R read, T mtime read in a window, I interrupt levels, P read and write together
I 00000000 0000000000000000 00 0 00 0 0000000000000002
R 02004000 0000000000000000 00 1 00 0 0000000000000000
W 02004000 1122334455667788 ff 2 00 0 0000000000000000
R 02004000 0000000000000000 00 3 00 0 1122334455667788
W 02004000 aabbccddeeff0011 0f 4 00 0 0000000000000000
R 02004000 0000000000000000 00 5 00 0 11223344eeff0011
W 02004000 9900000000000000 c0 6 00 0 0000000000000000
R 02004000 0000000000000000 00 7 00 0 99003344eeff0011
I 00000000 0000000000000000 00 0 00 0 0000000000000000
W 02000000 00000000000000ff 01 8 00 0 0000000000000000
R 02000000 0000000000000000 00 9 00 0 0000000000000001
I 00000000 0000000000000000 00 0 00 0 0000000000000001
W 02000000 0000000000000000 fe a 00 0 0000000000000000
I 00000000 0000000000000000 00 0 00 0 0000000000000001
W 02000000 0000000000000000 01 b 00 0 0000000000000000
I 00000000 0000000000000000 00 0 00 0 0000000000000000
W 02001000 ffffffffffffffff ff c 00 3 0000000000000000
R 02001000 0000000000000000 00 d 00 3 0000000000000000
W 02004000 0123456789abcdef ff e 01 2 0000000000000000
R 02004000 0000000000000000 00 f 00 0 99003344eeff0011
R 02004000 0000000000000000 00 1 01 2 0000000000000000
T 0200bff8 0000000100000000 ff 2 00 0 0000000000000000
T 0200bff8 0000000000000000 00 3 00 0 0000000000000000
W 02004000 0000000000000010 ff 4 00 0 0000000000000000
I 00000000 0000000000000000 00 0 00 0 0000000000000002
W 02004000 ffffffffffffffff ff 5 00 0 0000000000000000
I 00000000 0000000000000000 00 0 00 0 0000000000000000
P 02004000 0000000000001234 ff 6 00 0 ffffffffffffffff
R 02004000 0000000000000000 00 8 00 0 0000000000001234
I 00000000 0000000000000000 00 0 00 0 0000000000000002
